// ==== include/snes_cart_consts.svh ====
`ifndef SNES_CART_CONSTS_SVH
`define SNES_CART_CONSTS_SVH

// Bus widths
`define CPU_DATA_W     8
`define ROM_DATA_W     16
`define ROM_ADDR_W     24
`define COP_ROM_ADDR_W 23
`define BSRAM_ADDR_W   20
`define ARAM_ADDR_W    16

// Coprocessor mappers, one bit each in map_active
`define MAP_N   2
`define MAP_SA1 0
`define MAP_BSX 1

// Cartridge type code, upper nibble selects coprocessor carts
`define ROM_TYPE_W       8
`define ROM_TYPE_COP_MSB 7
`define ROM_TYPE_COP_LSB 4

`endif

// ==== src/snes_cart_pkg.sv ====
`default_nettype none

package snes_cart_pkg;

`include "snes_cart_consts.svh"

	typedef logic [`CPU_DATA_W-1:0]   byte_t;
	typedef logic [`ROM_ADDR_W-1:0]   rom_addr_t;
	typedef logic [`ROM_DATA_W-1:0]   rom_word_t;
	typedef logic [`BSRAM_ADDR_W-1:0] bsram_addr_t;
	typedef logic [`ARAM_ADDR_W-1:0]  aram_addr_t;

	// One-hot, indexed by MAP_SA1 / MAP_BSX
	typedef logic [`MAP_N-1:0]        map_active_t;

	typedef logic [`ROM_TYPE_W-1:0]   rom_type_t;

endpackage

`default_nettype wire

// ==== src/cart_bus_if.sv ====
`default_nettype none

// One mapper's view of the cartridge bus
interface cart_bus_if;
	snes_cart_pkg::rom_addr_t   rom_addr;
	snes_cart_pkg::rom_word_t   rom_d;
	logic                       rom_ce_n;
	logic                       rom_oe_n;
	logic                       rom_we_n;
	logic                       rom_word;

	snes_cart_pkg::bsram_addr_t bsram_addr;
	snes_cart_pkg::byte_t       bsram_d;
	logic                       bsram_ce_n;
	logic                       bsram_oe_n;
	logic                       bsram_we_n;

	snes_cart_pkg::byte_t       cpu_do;
	logic                       irq_n;

	modport mapper (
		output rom_addr, rom_d, rom_ce_n, rom_oe_n, rom_we_n, rom_word,
		output bsram_addr, bsram_d, bsram_ce_n, bsram_oe_n, bsram_we_n,
		output cpu_do, irq_n
	);

	modport sel (
		input rom_addr, rom_d, rom_ce_n, rom_oe_n, rom_we_n, rom_word,
		input bsram_addr, bsram_d, bsram_ce_n, bsram_oe_n, bsram_we_n,
		input cpu_do, irq_n
	);
endinterface

// Audio RAM port of the core
interface aram_bus_if;
	snes_cart_pkg::aram_addr_t addr;
	snes_cart_pkg::byte_t      d;
	logic                      ce_n;
	logic                      oe_n;
	logic                      we_n;

	modport src (output addr, d, ce_n, oe_n, we_n);
	modport dst (input addr, d, ce_n, oe_n, we_n);
endinterface

`default_nettype wire

// ==== src/mapper_select.sv ====
`default_nettype none

`include "snes_cart_consts.svh"

module mapper_select (
	input  logic                       mclk,
	input  logic                       rst,
	input  snes_cart_pkg::map_active_t map_active,
	input  snes_cart_pkg::rom_type_t   rom_type,
	input  logic                       ss_busy,
	cart_bus_if.sel                    dlh,
	cart_bus_if.sel                    sa1,
	cart_bus_if.sel                    bsx,
	cart_bus_if.mapper                 chosen,
	output logic                       ss_avail,
	output logic                       turbo_allow
);

	localparam snes_cart_pkg::map_active_t SA1_ONLY =
		snes_cart_pkg::map_active_t'(1 << `MAP_SA1);
	localparam snes_cart_pkg::map_active_t BSX_ONLY =
		snes_cart_pkg::map_active_t'(1 << `MAP_BSX);

	always_comb begin
		case (map_active)
		SA1_ONLY: begin
			chosen.cpu_do     = sa1.cpu_do;
			chosen.irq_n      = sa1.irq_n;
			chosen.rom_addr   = sa1.rom_addr;
			chosen.rom_d      = sa1.rom_d;
			chosen.rom_ce_n   = sa1.rom_ce_n;
			chosen.rom_oe_n   = sa1.rom_oe_n;
			chosen.rom_we_n   = sa1.rom_we_n;
			chosen.rom_word   = sa1.rom_word;
			chosen.bsram_addr = sa1.bsram_addr;
			chosen.bsram_d    = sa1.bsram_d;
			chosen.bsram_ce_n = sa1.bsram_ce_n;
			chosen.bsram_oe_n = sa1.bsram_oe_n;
			chosen.bsram_we_n = sa1.bsram_we_n;
		end
		BSX_ONLY: begin
			chosen.cpu_do     = bsx.cpu_do;
			chosen.irq_n      = bsx.irq_n;
			chosen.rom_addr   = bsx.rom_addr;
			chosen.rom_d      = bsx.rom_d;
			chosen.rom_ce_n   = bsx.rom_ce_n;
			chosen.rom_oe_n   = bsx.rom_oe_n;
			chosen.rom_we_n   = bsx.rom_we_n;
			chosen.rom_word   = bsx.rom_word;
			chosen.bsram_addr = bsx.bsram_addr;
			chosen.bsram_d    = bsx.bsram_d;
			chosen.bsram_ce_n = bsx.bsram_ce_n;
			chosen.bsram_oe_n = bsx.bsram_oe_n;
			chosen.bsram_we_n = bsx.bsram_we_n;
		end
		// Plain cart, or a broken map_active
		default: begin
			chosen.cpu_do     = dlh.cpu_do;
			chosen.irq_n      = dlh.irq_n;
			chosen.rom_addr   = dlh.rom_addr;
			chosen.rom_d      = dlh.rom_d;
			chosen.rom_ce_n   = dlh.rom_ce_n;
			chosen.rom_oe_n   = dlh.rom_oe_n;
			chosen.rom_we_n   = dlh.rom_we_n;
			chosen.rom_word   = dlh.rom_word;
			chosen.bsram_addr = dlh.bsram_addr;
			chosen.bsram_d    = dlh.bsram_d;
			chosen.bsram_ce_n = dlh.bsram_ce_n;
			chosen.bsram_oe_n = dlh.bsram_oe_n;
			chosen.bsram_we_n = dlh.bsram_we_n;
		end
		endcase
	end

	// Savestates work on basic carts and on SA1
	assign ss_avail = ~|rom_type[`ROM_TYPE_COP_MSB:`ROM_TYPE_COP_LSB] | map_active[`MAP_SA1];

	assign turbo_allow = ~(map_active[`MAP_SA1] | ss_busy);

	// The external mapper detection must never enable two coprocessors
	a_map_onehot: assert property (@(posedge mclk) disable iff (rst) $onehot0(map_active))
		else $error("map_active has more than one bit set: %b", map_active);

endmodule

`default_nettype wire

// ==== src/bus_override.sv ====
`default_nettype none

`include "snes_cart_consts.svh"

module bus_override (
	input  logic                       mclk,
	input  logic                       rst,
	cart_bus_if.sel                    chosen,
	aram_bus_if.dst                    core_aram,

	input  logic                       msu_sel,
	input  snes_cart_pkg::byte_t       msu_do,
	input  snes_cart_pkg::byte_t       ss_do,
	input  logic                       ss_do_ovr,
	input  logic                       ss_rom_ovr,
	input  snes_cart_pkg::rom_addr_t   ss_rom_addr,
	input  snes_cart_pkg::bsram_addr_t ss_ext_addr,
	input  logic                       ss_aram_sel,
	input  logic                       ss_bsram_sel,
	input  logic                       pard_n,
	input  logic                       pawr_n,

	output snes_cart_pkg::byte_t       cpu_di,
	output logic                       irq_n,
	output snes_cart_pkg::rom_addr_t   rom_addr,
	output snes_cart_pkg::rom_word_t   rom_d,
	output logic                       rom_ce_n,
	output logic                       rom_oe_n,
	output logic                       rom_we_n,
	output logic                       rom_word,
	output snes_cart_pkg::bsram_addr_t bsram_addr,
	output snes_cart_pkg::byte_t       bsram_d,
	output logic                       bsram_ce_n,
	output logic                       bsram_oe_n,
	output logic                       bsram_we_n,
	output snes_cart_pkg::aram_addr_t  aram_addr,
	output snes_cart_pkg::byte_t       aram_d,
	output logic                       aram_ce_n,
	output logic                       aram_oe_n,
	output logic                       aram_we_n
);

	// Savestate readback beats MSU, MSU beats the mapper
	assign cpu_di = ss_do_ovr ? ss_do : (msu_sel ? msu_do : chosen.cpu_do);

	assign irq_n    = chosen.irq_n;
	assign rom_addr = ss_rom_ovr ? ss_rom_addr : chosen.rom_addr;
	assign rom_d    = chosen.rom_d;
	assign rom_ce_n = chosen.rom_ce_n;
	assign rom_oe_n = chosen.rom_oe_n;
	assign rom_we_n = chosen.rom_we_n;
	assign rom_word = chosen.rom_word;

	always_comb begin
		if (ss_bsram_sel) begin
			bsram_addr = ss_ext_addr;
			bsram_d    = ss_do;
			bsram_ce_n = 1'b0;
			bsram_oe_n = pard_n;
			bsram_we_n = pawr_n;
		end else begin
			bsram_addr = chosen.bsram_addr;
			bsram_d    = chosen.bsram_d;
			bsram_ce_n = chosen.bsram_ce_n;
			bsram_oe_n = chosen.bsram_oe_n;
			bsram_we_n = chosen.bsram_we_n;
		end
	end

	// Audio RAM dump uses the B-bus strobes too
	always_comb begin
		if (ss_aram_sel) begin
			aram_addr = ss_ext_addr[`ARAM_ADDR_W-1:0];
			aram_d    = ss_do;
			aram_ce_n = 1'b0;
			aram_oe_n = pard_n;
			aram_we_n = pawr_n;
		end else begin
			aram_addr = core_aram.addr;
			aram_d    = core_aram.d;
			aram_ce_n = core_aram.ce_n;
			aram_oe_n = core_aram.oe_n;
			aram_we_n = core_aram.we_n;
		end
	end

	// The savestate engine walks one memory at a time
	a_ss_sel_excl: assert property (@(posedge mclk) disable iff (rst)
		!(ss_aram_sel && ss_bsram_sel))
		else $error("ss_aram_sel and ss_bsram_sel both high");

endmodule

`default_nettype wire

// ==== src/snes_cart_bus.sv ====
`default_nettype none

`include "snes_cart_consts.svh"

module snes_cart_bus (
	input  logic                       mclk,
	input  logic                       rst,
	input  snes_cart_pkg::map_active_t map_active,
	input  snes_cart_pkg::rom_type_t   rom_type,
	input  logic                       ss_busy,

	// Default LoROM/HiROM/DSP mapper
	input  snes_cart_pkg::byte_t       dlh_cpu_do,
	input  logic                       dlh_irq_n,
	input  snes_cart_pkg::rom_addr_t   dlh_rom_addr,
	input  logic                       dlh_rom_ce_n, dlh_rom_oe_n, dlh_rom_word,
	input  snes_cart_pkg::bsram_addr_t dlh_bsram_addr,
	input  snes_cart_pkg::byte_t       dlh_bsram_d,
	input  logic                       dlh_bsram_ce_n, dlh_bsram_oe_n, dlh_bsram_we_n,

	input  snes_cart_pkg::byte_t       sa1_cpu_do,
	input  logic                       sa1_irq_n,
	input  logic [`COP_ROM_ADDR_W-1:0] sa1_rom_addr,
	input  logic                       sa1_rom_ce_n, sa1_rom_oe_n, sa1_rom_word,
	input  snes_cart_pkg::bsram_addr_t sa1_bsram_addr,
	input  snes_cart_pkg::byte_t       sa1_bsram_d,
	input  logic                       sa1_bsram_ce_n, sa1_bsram_oe_n, sa1_bsram_we_n,

	// Satellaview, the only mapper that writes ROM
	input  snes_cart_pkg::byte_t       bsx_cpu_do,
	input  logic                       bsx_irq_n,
	input  logic [`COP_ROM_ADDR_W-1:0] bsx_rom_addr,
	input  snes_cart_pkg::rom_word_t   bsx_rom_d,
	input  logic                       bsx_rom_ce_n, bsx_rom_oe_n, bsx_rom_we_n,
	input  logic                       bsx_rom_word,
	input  snes_cart_pkg::bsram_addr_t bsx_bsram_addr,
	input  snes_cart_pkg::byte_t       bsx_bsram_d,
	input  logic                       bsx_bsram_ce_n, bsx_bsram_oe_n, bsx_bsram_we_n,

	input  snes_cart_pkg::aram_addr_t  core_aram_addr,
	input  snes_cart_pkg::byte_t       core_aram_d,
	input  logic                       core_aram_ce_n, core_aram_oe_n, core_aram_we_n,

	input  logic                       msu_sel,
	input  snes_cart_pkg::byte_t       msu_do,
	input  snes_cart_pkg::byte_t       ss_do,
	input  logic                       ss_do_ovr,
	input  logic                       ss_rom_ovr,
	input  snes_cart_pkg::rom_addr_t   ss_rom_addr,
	input  snes_cart_pkg::bsram_addr_t ss_ext_addr,
	input  logic                       ss_aram_sel, ss_bsram_sel,
	input  logic                       pard_n, pawr_n,

	output snes_cart_pkg::byte_t       cpu_di,
	output logic                       irq_n,
	output snes_cart_pkg::rom_addr_t   rom_addr,
	output snes_cart_pkg::rom_word_t   rom_d,
	output logic                       rom_ce_n, rom_oe_n, rom_we_n, rom_word,
	output snes_cart_pkg::bsram_addr_t bsram_addr,
	output snes_cart_pkg::byte_t       bsram_d,
	output logic                       bsram_ce_n, bsram_oe_n, bsram_we_n,
	output snes_cart_pkg::aram_addr_t  aram_addr,
	output snes_cart_pkg::byte_t       aram_d,
	output logic                       aram_ce_n, aram_oe_n, aram_we_n,
	output logic                       ss_avail,
	output logic                       turbo_allow
);

	cart_bus_if dlh ();
	cart_bus_if sa1 ();
	cart_bus_if bsx ();
	cart_bus_if chosen ();
	aram_bus_if core_aram ();

	assign dlh.cpu_do     = dlh_cpu_do;
	assign dlh.irq_n      = dlh_irq_n;
	assign dlh.rom_addr   = dlh_rom_addr;
	assign dlh.rom_d      = '0;
	assign dlh.rom_ce_n   = dlh_rom_ce_n;
	assign dlh.rom_oe_n   = dlh_rom_oe_n;
	assign dlh.rom_we_n   = 1'b1;
	assign dlh.rom_word   = dlh_rom_word;
	assign dlh.bsram_addr = dlh_bsram_addr;
	assign dlh.bsram_d    = dlh_bsram_d;
	assign dlh.bsram_ce_n = dlh_bsram_ce_n;
	assign dlh.bsram_oe_n = dlh_bsram_oe_n;
	assign dlh.bsram_we_n = dlh_bsram_we_n;

	// Coprocessors see only the lower 8 MB
	assign sa1.cpu_do     = sa1_cpu_do;
	assign sa1.irq_n      = sa1_irq_n;
	assign sa1.rom_addr   = {1'b0, sa1_rom_addr};
	assign sa1.rom_d      = '0;
	assign sa1.rom_ce_n   = sa1_rom_ce_n;
	assign sa1.rom_oe_n   = sa1_rom_oe_n;
	assign sa1.rom_we_n   = 1'b1;
	assign sa1.rom_word   = sa1_rom_word;
	assign sa1.bsram_addr = sa1_bsram_addr;
	assign sa1.bsram_d    = sa1_bsram_d;
	assign sa1.bsram_ce_n = sa1_bsram_ce_n;
	assign sa1.bsram_oe_n = sa1_bsram_oe_n;
	assign sa1.bsram_we_n = sa1_bsram_we_n;

	assign bsx.cpu_do     = bsx_cpu_do;
	assign bsx.irq_n      = bsx_irq_n;
	assign bsx.rom_addr   = {1'b0, bsx_rom_addr};
	assign bsx.rom_d      = bsx_rom_d;
	assign bsx.rom_ce_n   = bsx_rom_ce_n;
	assign bsx.rom_oe_n   = bsx_rom_oe_n;
	assign bsx.rom_we_n   = bsx_rom_we_n;
	assign bsx.rom_word   = bsx_rom_word;
	assign bsx.bsram_addr = bsx_bsram_addr;
	assign bsx.bsram_d    = bsx_bsram_d;
	assign bsx.bsram_ce_n = bsx_bsram_ce_n;
	assign bsx.bsram_oe_n = bsx_bsram_oe_n;
	assign bsx.bsram_we_n = bsx_bsram_we_n;

	assign core_aram.addr = core_aram_addr;
	assign core_aram.d    = core_aram_d;
	assign core_aram.ce_n = core_aram_ce_n;
	assign core_aram.oe_n = core_aram_oe_n;
	assign core_aram.we_n = core_aram_we_n;

	mapper_select u_mapper_select (
		.mclk        (mclk),
		.rst         (rst),
		.map_active  (map_active),
		.rom_type    (rom_type),
		.ss_busy     (ss_busy),
		.dlh         (dlh.sel),
		.sa1         (sa1.sel),
		.bsx         (bsx.sel),
		.chosen      (chosen.mapper),
		.ss_avail    (ss_avail),
		.turbo_allow (turbo_allow)
	);

	// Port names match the top level one to one
	bus_override u_bus_override (.*);

endmodule

`default_nettype wire

// ==== testbench/cart_bus_checker.sv ====
`default_nettype none

module cart_bus_checker (
	input  logic        mclk,
	input  logic        check_en,
	input  logic [2:0]  cpu_code,
	input  logic [2:0]  rom_code,
	input  logic [2:0]  bsram_code,
	input  logic [2:0]  aram_code,
	input  logic        exp_avail,
	input  logic        exp_turbo,
	input  logic        ss_rom_ovr,
	input  logic [83:0] dlh_bus,
	input  logic [83:0] sa1_bus,
	input  logic [83:0] bsx_bus,
	input  logic [26:0] core_aram,
	input  logic [7:0]  msu_do,
	input  logic [7:0]  ss_do,
	input  logic [23:0] ss_rom_addr,
	input  logic [19:0] ss_ext_addr,
	input  logic        pard_n,
	input  logic        pawr_n,
	input  logic [83:0] dut_bus,
	input  logic [26:0] dut_aram,
	input  logic        ss_avail,
	input  logic        turbo_allow,
	output int          errors
);
	timeunit 1ns;
	timeprecision 100ps;

	initial errors = 0;

	function automatic logic [83:0] pick(input logic [2:0] code);
		case (code)
		3'd1: return sa1_bus;
		3'd2: return bsx_bus;
		default: return dlh_bus;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("Error: %s expected %h got %h", name, exp, act);
		end
	endtask

	// Bus layout: cpu_do irq_n rom_addr rom_d rom ce/oe/we/word bsram_addr bsram_d ce/oe/we
	always @(posedge mclk) begin
		logic [83:0] m;
		logic [83:0] b;
		logic [7:0]  cpu;
		logic [23:0] ra;
		logic [30:0] bs;
		logic [26:0] ar;
		if (check_en) begin
			m = pick(rom_code);
			b = pick(cpu_code);
			cpu = (cpu_code == 3'd4) ? ss_do : (cpu_code == 3'd3) ? msu_do : b[83:76];
			ra = ss_rom_ovr ? ss_rom_addr : m[74:51];
			b = pick(bsram_code);
			bs = (bsram_code == 3'd4) ? {ss_ext_addr, ss_do, 1'b0, pard_n, pawr_n} : b[30:0];
			ar = (aram_code == 3'd4) ? {ss_ext_addr[15:0], ss_do, 1'b0, pard_n, pawr_n}
				: core_aram;
			compare("cpu_di", 32'(cpu), 32'(dut_bus[83:76]));
			compare("irq_n", 32'(m[75]), 32'(dut_bus[75]));
			compare("rom_addr", 32'(ra), 32'(dut_bus[74:51]));
			compare("rom_d", 32'(m[50:35]), 32'(dut_bus[50:35]));
			compare("rom_ce_n", 32'(m[34]), 32'(dut_bus[34]));
			compare("rom_oe_n", 32'(m[33]), 32'(dut_bus[33]));
			compare("rom_we_n", 32'(m[32]), 32'(dut_bus[32]));
			compare("rom_word", 32'(m[31]), 32'(dut_bus[31]));
			compare("bsram_addr", 32'(bs[30:11]), 32'(dut_bus[30:11]));
			compare("bsram_d", 32'(bs[10:3]), 32'(dut_bus[10:3]));
			compare("bsram_ce_n", 32'(bs[2]), 32'(dut_bus[2]));
			compare("bsram_oe_n", 32'(bs[1]), 32'(dut_bus[1]));
			compare("bsram_we_n", 32'(bs[0]), 32'(dut_bus[0]));
			compare("aram_addr", 32'(ar[26:11]), 32'(dut_aram[26:11]));
			compare("aram_d", 32'(ar[10:3]), 32'(dut_aram[10:3]));
			compare("aram_ce_n", 32'(ar[2]), 32'(dut_aram[2]));
			compare("aram_oe_n", 32'(ar[1]), 32'(dut_aram[1]));
			compare("aram_we_n", 32'(ar[0]), 32'(dut_aram[0]));
			compare("ss_avail", 32'(exp_avail), 32'(ss_avail));
			compare("turbo_allow", 32'(exp_turbo), 32'(turbo_allow));
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_snes_cart_bus.sv ====
`default_nettype none

module tb_snes_cart_bus;
	timeunit 1ns;
	timeprecision 100ps;

	logic        mclk = 1'b0;
	logic        rst;
	logic        check_en;
	logic [83:0] dlh_raw, sa1_raw, bsx_raw;
	logic [26:0] aram_raw;
	// msu_do, ss_do, ss_rom_addr, ss_ext_addr, pard_n, pawr_n
	logic [61:0] misc_raw;
	logic [1:0]  map_active;
	logic [7:0]  rom_type;
	logic        ss_busy, msu_sel, ss_do_ovr, ss_rom_ovr, ss_bsram_sel, ss_aram_sel;
	logic [2:0]  cpu_code, rom_code, bsram_code, aram_code;
	logic        exp_avail, exp_turbo;

	logic [7:0]  cpu_di, bsram_d, aram_d;
	logic [23:0] rom_addr;
	logic [15:0] rom_d, aram_addr;
	logic [19:0] bsram_addr;
	logic        irq_n, rom_ce_n, rom_oe_n, rom_we_n, rom_word;
	logic        bsram_ce_n, bsram_oe_n, bsram_we_n, aram_ce_n, aram_oe_n, aram_we_n;
	logic        ss_avail, turbo_allow;

	logic [83:0] dlh_exp, sa1_exp, bsx_exp;
	int          errors;
	int          cycles = 0;
	int          limit = 1000;
	logic [31:0] seed = 32'h9f08;
	string       case_lines[$];

	always #10 mclk = ~mclk;

	// DLH and SA1 never write ROM, coprocessor addresses have a zero top bit
	assign dlh_exp = {dlh_raw[83:51], 16'h0, dlh_raw[34:33], 1'b1, dlh_raw[31:0]};
	assign sa1_exp = {sa1_raw[83:75], 1'b0, sa1_raw[73:51], 16'h0, sa1_raw[34:33], 1'b1,
		sa1_raw[31:0]};
	assign bsx_exp = {bsx_raw[83:75], 1'b0, bsx_raw[73:0]};

	snes_cart_bus dut (
		.mclk(mclk), .rst(rst), .map_active(map_active), .rom_type(rom_type),
		.ss_busy(ss_busy),
		.dlh_cpu_do(dlh_raw[83:76]), .dlh_irq_n(dlh_raw[75]), .dlh_rom_addr(dlh_raw[74:51]),
		.dlh_rom_ce_n(dlh_raw[34]), .dlh_rom_oe_n(dlh_raw[33]), .dlh_rom_word(dlh_raw[31]),
		.dlh_bsram_addr(dlh_raw[30:11]), .dlh_bsram_d(dlh_raw[10:3]),
		.dlh_bsram_ce_n(dlh_raw[2]), .dlh_bsram_oe_n(dlh_raw[1]), .dlh_bsram_we_n(dlh_raw[0]),
		.sa1_cpu_do(sa1_raw[83:76]), .sa1_irq_n(sa1_raw[75]), .sa1_rom_addr(sa1_raw[73:51]),
		.sa1_rom_ce_n(sa1_raw[34]), .sa1_rom_oe_n(sa1_raw[33]), .sa1_rom_word(sa1_raw[31]),
		.sa1_bsram_addr(sa1_raw[30:11]), .sa1_bsram_d(sa1_raw[10:3]),
		.sa1_bsram_ce_n(sa1_raw[2]), .sa1_bsram_oe_n(sa1_raw[1]), .sa1_bsram_we_n(sa1_raw[0]),
		.bsx_cpu_do(bsx_raw[83:76]), .bsx_irq_n(bsx_raw[75]), .bsx_rom_addr(bsx_raw[73:51]),
		.bsx_rom_d(bsx_raw[50:35]), .bsx_rom_ce_n(bsx_raw[34]), .bsx_rom_oe_n(bsx_raw[33]),
		.bsx_rom_we_n(bsx_raw[32]), .bsx_rom_word(bsx_raw[31]),
		.bsx_bsram_addr(bsx_raw[30:11]), .bsx_bsram_d(bsx_raw[10:3]),
		.bsx_bsram_ce_n(bsx_raw[2]), .bsx_bsram_oe_n(bsx_raw[1]), .bsx_bsram_we_n(bsx_raw[0]),
		.core_aram_addr(aram_raw[26:11]), .core_aram_d(aram_raw[10:3]),
		.core_aram_ce_n(aram_raw[2]), .core_aram_oe_n(aram_raw[1]), .core_aram_we_n(aram_raw[0]),
		.msu_sel(msu_sel), .msu_do(misc_raw[61:54]), .ss_do(misc_raw[53:46]),
		.ss_do_ovr(ss_do_ovr), .ss_rom_ovr(ss_rom_ovr), .ss_rom_addr(misc_raw[45:22]),
		.ss_ext_addr(misc_raw[21:2]), .ss_aram_sel(ss_aram_sel), .ss_bsram_sel(ss_bsram_sel),
		.pard_n(misc_raw[1]), .pawr_n(misc_raw[0]),
		.cpu_di(cpu_di), .irq_n(irq_n), .rom_addr(rom_addr), .rom_d(rom_d),
		.rom_ce_n(rom_ce_n), .rom_oe_n(rom_oe_n), .rom_we_n(rom_we_n), .rom_word(rom_word),
		.bsram_addr(bsram_addr), .bsram_d(bsram_d), .bsram_ce_n(bsram_ce_n),
		.bsram_oe_n(bsram_oe_n), .bsram_we_n(bsram_we_n),
		.aram_addr(aram_addr), .aram_d(aram_d), .aram_ce_n(aram_ce_n),
		.aram_oe_n(aram_oe_n), .aram_we_n(aram_we_n),
		.ss_avail(ss_avail), .turbo_allow(turbo_allow)
	);

	cart_bus_checker bus_check (
		.mclk(mclk), .check_en(check_en), .cpu_code(cpu_code), .rom_code(rom_code),
		.bsram_code(bsram_code), .aram_code(aram_code), .exp_avail(exp_avail),
		.exp_turbo(exp_turbo), .ss_rom_ovr(ss_rom_ovr),
		.dlh_bus(dlh_exp), .sa1_bus(sa1_exp), .bsx_bus(bsx_exp), .core_aram(aram_raw),
		.msu_do(misc_raw[61:54]), .ss_do(misc_raw[53:46]), .ss_rom_addr(misc_raw[45:22]),
		.ss_ext_addr(misc_raw[21:2]), .pard_n(misc_raw[1]), .pawr_n(misc_raw[0]),
		.dut_bus({cpu_di, irq_n, rom_addr, rom_d, rom_ce_n, rom_oe_n, rom_we_n, rom_word,
			bsram_addr, bsram_d, bsram_ce_n, bsram_oe_n, bsram_we_n}),
		.dut_aram({aram_addr, aram_d, aram_ce_n, aram_oe_n, aram_we_n}),
		.ss_avail(ss_avail), .turbo_allow(turbo_allow), .errors(errors)
	);

	// Low LCG bits repeat quickly, so fold in the high half
	function automatic logic [31:0] rnd();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed ^ (seed >> 16);
	endfunction

	always @(posedge mclk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles, the case sequence did not finish", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		int          fd;
		int          n;
		int          load_fail;
		string       line;
		logic [95:0] r;
		logic [7:0]  f[14];
		rst = 1'b1;
		check_en = 1'b0;
		{dlh_raw, sa1_raw, bsx_raw, aram_raw, misc_raw} = '0;
		{map_active, rom_type, ss_busy, msu_sel, ss_do_ovr} = '0;
		{ss_rom_ovr, ss_bsram_sel, ss_aram_sel, exp_avail, exp_turbo} = '0;
		{cpu_code, rom_code, bsram_code, aram_code} = '0;
		load_fail = 0;
		fd = $fopen("testbench/snes_cart_bus_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file testbench/snes_cart_bus_cases.txt");
			load_fail = 1;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 1 && line[0] != "#")
					case_lines.push_back(line);
			end
			$fclose(fd);
		end
		limit = 8 + 2 * case_lines.size() + 20;

		repeat (8) @(posedge mclk);
		rst <= 1'b0;
		foreach (case_lines[i]) begin
			@(posedge mclk);
			n = $sscanf(case_lines[i], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
				f[8], f[9], f[10], f[11], f[12], f[13]);
			if (n != 14) begin
				$display("Case line %0d could not be parsed", i);
				load_fail = 1;
			end
			r = {rnd(), rnd(), rnd()};
			dlh_raw <= r[83:0];
			r = {rnd(), rnd(), rnd()};
			sa1_raw <= r[83:0];
			r = {rnd(), rnd(), rnd()};
			bsx_raw <= r[83:0];
			r = {rnd(), rnd(), rnd()};
			aram_raw <= r[26:0];
			misc_raw <= r[95:34];
			map_active <= f[0][1:0];
			rom_type <= f[1];
			ss_busy <= f[2][0];
			msu_sel <= f[3][0];
			ss_do_ovr <= f[4][0];
			ss_rom_ovr <= f[5][0];
			ss_bsram_sel <= f[6][0];
			ss_aram_sel <= f[7][0];
			cpu_code <= f[8][2:0];
			rom_code <= f[9][2:0];
			bsram_code <= f[10][2:0];
			aram_code <= f[11][2:0];
			exp_avail <= f[12][0];
			exp_turbo <= f[13][0];
			// Illegal selects are exercised with the assertions held off
			rst <= (f[0][1:0] == 2'b11) || (f[6][0] && f[7][0]);
			check_en <= (n == 14);
			@(posedge mclk);
			check_en <= 1'b0;
		end
		@(posedge mclk);
		$display("Cases run: %0d, errors: %0d", case_lines.size(), errors + load_fail);
		if (errors == 0 && load_fail == 0 && case_lines.size() > 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== snes_cart_bus.f ====
+incdir+include
src/snes_cart_pkg.sv
src/cart_bus_if.sv
src/mapper_select.sv
src/bus_override.sv
src/snes_cart_bus.sv
testbench/cart_bus_checker.sv
testbench/tb_snes_cart_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the snes_cart_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_snes_cart_bus -f snes_cart_bus.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_snes_cart_bus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
	exit 0
fi
exit 1

// ==== testbench/snes_cart_bus_cases.txt ====
# map rom_type busy msu ss_do_ovr ss_rom_ovr ss_bsram ss_aram | cpu rom bsram aram | avail turbo
# source codes: 0 dlh, 1 sa1, 2 bsx, 3 msu or core audio RAM, 4 savestate
0 00 0 0 0 0 0 0 0 0 0 3 1 1
3 20 0 0 0 0 0 0 0 0 0 3 1 0
1 35 0 0 0 0 0 0 1 1 1 3 1 0
2 20 0 0 0 0 0 0 2 2 2 3 0 1
2 00 1 0 0 0 0 0 2 2 2 3 1 0
0 00 0 1 0 0 0 0 3 0 0 3 1 1
0 00 0 0 1 0 0 0 4 0 0 3 1 1
1 f3 0 1 1 0 0 0 4 1 1 3 1 0
2 05 0 1 0 0 0 0 3 2 2 3 1 1
0 00 0 0 0 1 0 0 0 0 0 3 1 1
0 00 0 0 0 0 1 0 0 0 4 3 1 1
1 10 1 0 0 0 0 1 1 1 1 4 1 0
2 00 0 0 1 1 1 0 4 2 4 3 1 1
0 a0 1 0 0 1 0 1 0 0 0 4 0 0
1 00 0 1 0 1 1 0 3 1 4 3 1 0
2 f0 1 1 1 0 0 1 4 2 2 4 0 0
0 00 0 0 0 0 1 1 0 0 4 4 1 1
